// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -Wno-fatal -j 0
TOP       = tb_exec_core
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/alu_pkg.sv
package alu_pkg;

  // Operations understood by the executor.
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov,
    op_shl,
    op_shr,
    op_mul
  } op_e;

  // Bit positions inside the nine-bit flag register.
  localparam int fl_cf = 0;
  localparam int fl_pf = 1;
  localparam int fl_af = 2;
  localparam int fl_zf = 3;
  localparam int fl_sf = 4;
  localparam int fl_tf = 5;
  localparam int fl_if = 6;
  localparam int fl_df = 7;
  localparam int fl_of = 8;

  // One shift-add iteration per multiplier bit.
  localparam int mul_steps = 16;

endpackage

// File: common/cpu_pkg.sv
package cpu_pkg;

  // Datapath and register file geometry.
  localparam int word_w     = 16;
  localparam int reg_addr_w = 4;
  localparam int flag_w     = 9;

  // Fixed register codes in the 8086 word numbering.
  localparam logic [reg_addr_w-1:0] reg_ax = 4'd0;
  localparam logic [reg_addr_w-1:0] reg_cx = 4'd1;
  localparam logic [reg_addr_w-1:0] reg_dx = 4'd2;
  localparam logic [reg_addr_w-1:0] reg_cs = 4'd9;
  localparam logic [reg_addr_w-1:0] reg_ip = 4'd15;

  // The core comes out of reset at f000:fff0.
  localparam logic [word_w-1:0] cs_reset = 16'hf000;
  localparam logic [word_w-1:0] ip_reset = 16'hfff0;

  // Shift counts use the low five bits of CL.
  localparam int shift_cnt_mask = 5;

endpackage

// File: regfile/regfile.sv
module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [2*cpu_pkg::word_w-1:0]  d,
  input  logic                          wr,
  input  logic                          wrfl,
  input  logic                          wrhi,
  input  logic                          word_op,
  input  logic [cpu_pkg::reg_addr_w-1:0] addr_a,
  input  logic [cpu_pkg::reg_addr_w-1:0] addr_b,
  input  logic [cpu_pkg::reg_addr_w-1:0] addr_c,
  input  logic [cpu_pkg::reg_addr_w-1:0] addr_d,
  input  logic [1:0]                    addr_s,
  input  logic                          a_byte,
  input  logic                          b_byte,
  input  logic                          c_byte,
  input  logic [cpu_pkg::flag_w-1:0]    iflags,
  output logic [cpu_pkg::word_w-1:0]    a,
  output logic [cpu_pkg::word_w-1:0]    b,
  output logic [cpu_pkg::word_w-1:0]    c,
  output logic [cpu_pkg::word_w-1:0]    s,
  output logic [cpu_pkg::word_w-1:0]    cs,
  output logic [cpu_pkg::word_w-1:0]    ip,
  output logic [cpu_pkg::flag_w-1:0]    flags,
  output logic                          cx_zero
);

  logic [cpu_pkg::word_w-1:0] r [16];
  logic [cpu_pkg::word_w-1:0] cx_next;

  // Byte codes 0-3 pick a low byte, 4-7 the high byte of the same register.
  function automatic logic [cpu_pkg::word_w-1:0] read_port(
    input logic [cpu_pkg::reg_addr_w-1:0] addr,
    input logic                           is_byte
  );
    logic [cpu_pkg::word_w-1:0] base;
    logic [7:0]                 sel;
    base = r[{2'b00, addr[1:0]}];
    sel  = addr[2] ? base[15:8] : base[7:0];
    if (is_byte && !addr[3]) begin
      return {{8{sel[7]}}, sel};
    end
    return r[addr];
  endfunction

  always_comb begin
    a = read_port(addr_a, a_byte);
    b = read_port(addr_b, b_byte);
    c = read_port(addr_c, c_byte);
  end

  assign s  = r[{2'b10, addr_s}];
  assign cs = r[cpu_pkg::reg_cs];
  assign ip = r[cpu_pkg::reg_ip];

  // CX as it will be after the write in flight, so loops see the new count.
  always_comb begin
    cx_next = r[cpu_pkg::reg_cx];
    if (wr && addr_d == cpu_pkg::reg_cx) begin
      cx_next = word_op ? d[15:0] : {r[cpu_pkg::reg_cx][15:8], d[7:0]};
    end else if (wr && !word_op && addr_d == (cpu_pkg::reg_cx | 4'd4)) begin
      cx_next = {d[7:0], r[cpu_pkg::reg_cx][7:0]}; // CH write.
    end
  end

  assign cx_zero = (cx_next == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        r[i] <= '0;
      end
      r[cpu_pkg::reg_cs] <= cpu_pkg::cs_reset;
      r[cpu_pkg::reg_ip] <= cpu_pkg::ip_reset;
      flags              <= '0;
    end else begin
      if (wr) begin
        if (word_op || addr_d[3:2] == 2'b10) begin
          r[addr_d] <= word_op ? d[15:0] : {{8{d[7]}}, d[7:0]};
        end else if (addr_d[3] == addr_d[2]) begin
          r[addr_d][7:0] <= d[7:0];
        end else begin
          r[{2'b00, addr_d[1:0]}][15:8] <= d[7:0];
        end
      end
      if (wrfl) flags <= iflags;
      if (wrhi) r[cpu_pkg::reg_dx] <= d[31:16]; // Upper product word.
    end
  end

endmodule

// File: test/exec_checker.sv
module exec_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic                           busy,
  input  logic                           done,
  input  logic                           cx_zero,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_addr,
  input  logic [cpu_pkg::word_w-1:0]     rd_data,
  input  logic [cpu_pkg::word_w-1:0]     cs,
  input  logic [cpu_pkg::word_w-1:0]     ip,
  input  logic [cpu_pkg::flag_w-1:0]     flags,
  input  logic                           rd_check,
  input  logic [cpu_pkg::word_w-1:0]     exp_rd,
  input  logic [cpu_pkg::word_w-1:0]     exp_cs,
  input  logic [cpu_pkg::word_w-1:0]     exp_ip,
  input  logic [cpu_pkg::flag_w-1:0]     exp_flags,
  input  logic                           exp_cx_zero,
  input  int                             exp_lat,
  output int                             errors
);

  int   err_count = 0;
  int   cyc = 0;     // Cycles since the accepted start edge.
  logic armed = 1'b0;

  assign errors = err_count;

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    err_count++;
  endtask

  // Sampled mid-cycle, long after the bench has driven its inputs.
  always @(negedge clk) begin
    if (rst) begin
      armed = 1'b0;
    end else begin
      if (armed) begin
        cyc++;
        if (!busy) report_failure("busy is low between start and done");
        if (done) begin
          armed = 1'b0;
          if (cyc != exp_lat) report_mismatch("done latency", cyc, exp_lat);
          if (cx_zero !== exp_cx_zero) begin
            report_mismatch("cx_zero at write-back", cx_zero, exp_cx_zero); // Bypass path.
          end
        end
      end else if (done) begin
        report_failure("done pulsed without an accepted start");
      end
      if (start && !busy) begin
        cyc   = 0;
        armed = 1'b1;
      end
      if (rd_check) begin
        if (busy) report_failure("busy is high in an idle cycle");
        if (rd_data !== exp_rd) begin
          report_mismatch($sformatf("register %0d", rd_addr), rd_data, exp_rd);
        end
        if (flags !== exp_flags) report_mismatch("flags", flags, exp_flags);
        if (cx_zero !== exp_cx_zero) report_mismatch("cx_zero", cx_zero, exp_cx_zero);
        if (cs !== exp_cs) report_mismatch("cs", cs, exp_cs);
        if (ip !== exp_ip) report_mismatch("ip", ip, exp_ip);
      end
    end
  end

endmodule

// File: test/tb_exec_core.sv
module tb_exec_core;

  localparam int n_tests     = 3;
  localparam int n_instr     = 300;
  localparam int n_setup     = 12;
  localparam int clk_period  = 40;
  localparam int drive_delay = 2;
  localparam int watchdog_time = n_tests * (n_setup + n_instr) * 40 * clk_period + 100000;

  logic                           clk, rst, start, word_op, use_imm, busy, done, cx_zero;
  logic                           rd_check, exp_cx_zero;
  alu_pkg::op_e                   op;
  logic [cpu_pkg::reg_addr_w-1:0] dst, src, rd_addr;
  logic [cpu_pkg::word_w-1:0]     imm, rd_data, cs, ip, exp_rd, exp_cs, exp_ip;
  logic [cpu_pkg::flag_w-1:0]     flags, exp_flags, mflags;
  logic [cpu_pkg::word_w-1:0]     m [16]; // Reference copy of the register file.
  int                             exp_lat, errors;

  assign exp_rd      = m[rd_addr];
  assign exp_cs      = m[cpu_pkg::reg_cs];
  assign exp_ip      = m[cpu_pkg::reg_ip];
  assign exp_flags   = mflags;
  assign exp_cx_zero = (m[cpu_pkg::reg_cx] == '0);

  exec_core i_dut (
    .clk, .rst, .start, .op, .word_op, .dst, .src, .imm, .use_imm, .rd_addr,
    .busy, .done, .rd_data, .flags, .cs, .ip, .cx_zero
  );

  exec_checker i_checker (
    .clk, .rst, .start, .busy, .done, .cx_zero, .rd_addr, .rd_data, .cs, .ip, .flags,
    .rd_check, .exp_rd, .exp_cs, .exp_ip, .exp_flags, .exp_cx_zero, .exp_lat, .errors
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_time);
    $display("Timeout: the run did not finish within %0d time units", watchdog_time);
    $display("Checks failed");
    $finish;
  end

  function automatic string test_name(input int kind);
    case (kind)
      0:       return "mixed";
      1:       return "byte_alu";
      default: return "shift_mul";
    endcase
  endfunction

  // Byte codes 0-3 are the low bytes, 4-7 the high bytes of the same registers.
  function automatic logic [15:0] read_reg(input logic [3:0] code, input logic byte_op);
    if (byte_op && code < 8) begin
      return code[2] ? {8'h00, m[code[1:0]][15:8]} : {8'h00, m[code[1:0]][7:0]};
    end
    return m[code];
  endfunction

  task automatic write_reg(input logic [3:0] code, input logic byte_op, input logic [15:0] v);
    if (!byte_op) m[code] = v;
    else if (code >= 8) m[code] = {{8{v[7]}}, v[7:0]}; // Segment byte writes sign-extend.
    else if (code[2]) m[code[1:0]][15:8] = v[7:0];
    else m[code[1:0]][7:0] = v[7:0];
  endtask

  task automatic model_step(input alu_pkg::op_e o, input logic wd, input logic [3:0] dc,
                            input logic [3:0] sc, input logic [15:0] iv, input logic ui);
    logic [16:0] r;
    logic [15:0] x, y, mask;
    logic [31:0] p;
    logic [8:0]  f;
    int          w, n;
    w       = wd ? 16 : 8;
    mask    = wd ? 16'hffff : 16'h00ff;
    x       = read_reg(dc, !wd) & mask;
    y       = (ui ? iv : read_reg(sc, !wd)) & mask;
    f       = mflags;
    r       = '0;
    p       = '0;
    exp_lat = 1;
    case (o)
      alu_pkg::op_add, alu_pkg::op_sub: begin
        if (o == alu_pkg::op_add) begin
          r = {1'b0, x} + {1'b0, y};
          f[alu_pkg::fl_cf] = r[w];
          f[alu_pkg::fl_of] = (x[w-1] == y[w-1]) && (r[w-1] != x[w-1]);
        end else begin
          r = {1'b0, x} - {1'b0, y};
          f[alu_pkg::fl_cf] = (x < y);
          f[alu_pkg::fl_of] = (x[w-1] != y[w-1]) && (r[w-1] != x[w-1]);
        end
        f[alu_pkg::fl_af] = x[4] ^ y[4] ^ r[4];
      end
      alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor: begin
        r = (o == alu_pkg::op_and) ? {1'b0, x & y} :
            (o == alu_pkg::op_or) ? {1'b0, x | y} : {1'b0, x ^ y};
        f[alu_pkg::fl_cf] = 1'b0;
        f[alu_pkg::fl_of] = 1'b0;
      end
      alu_pkg::op_mov: r = {1'b0, y};
      alu_pkg::op_shl, alu_pkg::op_shr: begin
        n = int'(m[cpu_pkg::reg_cx][4:0]);
        r = {1'b0, x};
        for (int i = 0; i < n; i++) begin
          f[alu_pkg::fl_cf] = (o == alu_pkg::op_shl) ? r[w-1] : r[0];
          r = (o == alu_pkg::op_shl) ? (r << 1) & {1'b0, mask} : r >> 1;
        end
        f[alu_pkg::fl_of] = 1'b0;
        exp_lat = n + 2;
      end
      default: begin
        p = 32'(m[cpu_pkg::reg_ax]) * 32'(ui ? iv : m[sc]); // Word MUL into DX:AX.
        exp_lat = alu_pkg::mul_steps + 2;
      end
    endcase
    if (o == alu_pkg::op_mul) begin
      m[cpu_pkg::reg_ax] = p[15:0];
      m[cpu_pkg::reg_dx] = p[31:16];
      f[alu_pkg::fl_cf]  = |p[31:16];
      f[alu_pkg::fl_of]  = |p[31:16];
    end else begin
      if (o != alu_pkg::op_mov) begin
        f[alu_pkg::fl_zf] = ((r[15:0] & mask) == '0);
        f[alu_pkg::fl_sf] = r[w-1];
        f[alu_pkg::fl_pf] = ~^r[7:0];
      end
      write_reg(dc, !wd, r[15:0]);
    end
    mflags = f;
  endtask

  task automatic issue(input alu_pkg::op_e o, input logic wd, input logic [3:0] dc,
                       input logic [3:0] sc, input logic [15:0] iv, input logic ui);
    model_step(o, wd, dc, sc, iv, ui);
    start   = 1'b1;
    op      = o;
    word_op = wd;
    dst     = dc;
    src     = sc;
    imm     = iv;
    use_imm = ui;
    @(posedge clk);
    #drive_delay;
    // A second start while busy is ignored, so its fields can be anything.
    start = ($urandom_range(3, 0) == 0);
    op    = alu_pkg::op_e'($urandom_range(8, 0));
    dst   = 4'($urandom_range(15, 0));
    while (!done) begin
      @(posedge clk);
      #drive_delay;
      start = 1'b0;
    end
  endtask

  task automatic sweep_registers(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      #drive_delay;
      start    = 1'b0;
      rd_addr  = 4'(i);
      rd_check = 1'b1;
    end
    @(posedge clk);
    #drive_delay;
    rd_check = 1'b0;
  endtask

  task automatic load_registers();
    logic [15:0] v;
    for (int code = 0; code < n_setup; code++) begin
      v = ($urandom_range(3, 0) == 0) ? 16'h0000 : 16'($urandom);
      issue(alu_pkg::op_mov, 1'b1, 4'(code), 4'd0, v, 1'b1);
      @(posedge clk);
      #drive_delay;
      start = 1'b0;
    end
    sweep_registers(n_setup);
  endtask

  task automatic random_instr(input int kind);
    alu_pkg::op_e o;
    logic         wd;
    case (kind)
      0:       o = alu_pkg::op_e'($urandom_range(8, 0));
      1:       o = alu_pkg::op_e'($urandom_range(5, 0));
      default: o = alu_pkg::op_e'($urandom_range(8, 6));
    endcase
    wd = (kind == 1) ? 1'b0 : 1'($urandom_range(1, 0));
    issue(o, wd, 4'($urandom_range(11, 0)), 4'($urandom_range(11, 0)), 16'($urandom),
          1'($urandom_range(1, 0)));
  endtask

  initial begin
    int seed;
    int err_start;
    seed     = $urandom(39968);
    rst      = 1'b1;
    start    = 1'b0;
    op       = alu_pkg::op_add;
    word_op  = 1'b0;
    dst      = '0;
    src      = '0;
    imm      = '0;
    use_imm  = 1'b0;
    rd_addr  = '0;
    rd_check = 1'b0;
    exp_lat  = 0;
    for (int i = 0; i < 16; i++) begin
      m[i] = '0;
    end
    m[cpu_pkg::reg_cs] = cpu_pkg::cs_reset;
    m[cpu_pkg::reg_ip] = cpu_pkg::ip_reset;
    mflags             = '0;
    repeat (5) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
    sweep_registers(16);
    $display("reset check: %0d errors", errors);
    for (int t = 0; t < n_tests; t++) begin
      err_start = errors;
      load_registers();
      for (int i = 0; i < n_instr; i++) begin
        random_instr(t);
        sweep_registers(n_setup);
      end
      $display("test %0d (%s): %0d instructions, %0d errors", t, test_name(t), n_instr,
               errors - err_start);
    end
    sweep_registers(16);
    $display("%0d tests, %0d instructions, %0d errors", n_tests,
             n_tests * (n_setup + n_instr), errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog/alu.sv
module alu (
  input  alu_pkg::op_e                op,
  input  logic                        word_op,
  input  logic [cpu_pkg::word_w-1:0]  x,
  input  logic [cpu_pkg::word_w-1:0]  y,
  input  logic [cpu_pkg::flag_w-1:0]  flags_in,
  output logic [cpu_pkg::word_w-1:0]  result,
  output logic [cpu_pkg::flag_w-1:0]  flags_out
);

  logic [16:0] add_w, sub_w;
  logic [8:0]  add_b, sub_b;
  logic        xs, ys, rs, res_zero, res_par;
  logic        c_f, p_f, a_f, z_f, s_f, o_f;

  assign add_w = {1'b0, x} + {1'b0, y};
  assign sub_w = {1'b0, x} - {1'b0, y};
  assign add_b = {1'b0, x[7:0]} + {1'b0, y[7:0]};
  assign sub_b = {1'b0, x[7:0]} - {1'b0, y[7:0]};

  always_comb begin
    case (op)
      alu_pkg::op_add: result = add_w[15:0];
      alu_pkg::op_sub: result = sub_w[15:0];
      alu_pkg::op_and: result = x & y;
      alu_pkg::op_or:  result = x | y;
      alu_pkg::op_xor: result = x ^ y;
      alu_pkg::op_mov: result = y;
      default:         result = x;
    endcase
  end

  // Sign and zero are taken at the operand width.
  assign xs       = word_op ? x[15] : x[7];
  assign ys       = word_op ? y[15] : y[7];
  assign rs       = word_op ? result[15] : result[7];
  assign res_zero = word_op ? (result == '0) : (result[7:0] == '0);
  assign res_par  = ~^result[7:0];

  always_comb begin
    c_f = flags_in[alu_pkg::fl_cf];
    p_f = flags_in[alu_pkg::fl_pf];
    a_f = flags_in[alu_pkg::fl_af];
    z_f = flags_in[alu_pkg::fl_zf];
    s_f = flags_in[alu_pkg::fl_sf];
    o_f = flags_in[alu_pkg::fl_of];
    case (op)
      alu_pkg::op_add, alu_pkg::op_sub: begin
        if (op == alu_pkg::op_add) begin
          c_f = word_op ? add_w[16] : add_b[8];
          o_f = (xs == ys) && (rs != xs);
        end else begin
          c_f = word_op ? sub_w[16] : sub_b[8]; // Borrow.
          o_f = (xs != ys) && (rs != xs);
        end
        a_f = x[4] ^ y[4] ^ result[4];
        p_f = res_par;
        z_f = res_zero;
        s_f = rs;
      end
      alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor: begin
        c_f = 1'b0;
        o_f = 1'b0;
        p_f = res_par;
        z_f = res_zero;
        s_f = rs;
      end
      default: ;
    endcase
    flags_out[alu_pkg::fl_cf] = c_f;
    flags_out[alu_pkg::fl_pf] = p_f;
    flags_out[alu_pkg::fl_af] = a_f;
    flags_out[alu_pkg::fl_zf] = z_f;
    flags_out[alu_pkg::fl_sf] = s_f;
    flags_out[alu_pkg::fl_tf] = flags_in[alu_pkg::fl_tf];
    flags_out[alu_pkg::fl_if] = flags_in[alu_pkg::fl_if];
    flags_out[alu_pkg::fl_df] = flags_in[alu_pkg::fl_df];
    flags_out[alu_pkg::fl_of] = o_f;
  end

endmodule

// File: verilog/exec_core.sv
module exec_core (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  alu_pkg::op_e                    op,
  input  logic                            word_op,
  input  logic [cpu_pkg::reg_addr_w-1:0]  dst,
  input  logic [cpu_pkg::reg_addr_w-1:0]  src,
  input  logic [cpu_pkg::word_w-1:0]      imm,
  input  logic                            use_imm,
  input  logic [cpu_pkg::reg_addr_w-1:0]  rd_addr,
  output logic                            busy,
  output logic                            done,
  output logic [cpu_pkg::word_w-1:0]      rd_data,
  output logic [cpu_pkg::flag_w-1:0]      flags,
  output logic [cpu_pkg::word_w-1:0]      cs,
  output logic [cpu_pkg::word_w-1:0]      ip,
  output logic                            cx_zero
);

  logic [cpu_pkg::reg_addr_w-1:0]      addr_a, addr_b, addr_d;
  logic [cpu_pkg::word_w-1:0]          rf_a, rf_b, y_op, imm_q, alu_result;
  logic [2*cpu_pkg::word_w-1:0]        d, sm_result;
  logic [cpu_pkg::flag_w-1:0]          iflags, alu_flags, sm_flags;
  logic [cpu_pkg::shift_cnt_mask-1:0]  cl_count, cnt_init;
  alu_pkg::op_e                        alu_op;
  logic                                rf_word_op, y_sel_imm, wr, wrhi, wrfl;
  logic                                cnt_load, cnt_dec, cnt_zero, sm_load, sm_step;

  assign y_op     = y_sel_imm ? imm_q : rf_b;
  assign cl_count = rf_b[cpu_pkg::shift_cnt_mask-1:0];

  regfile i_regfile (
    .clk, .rst, .d, .wr, .wrfl, .wrhi,
    .word_op (rf_word_op),
    .addr_a, .addr_b,
    .addr_c  (rd_addr),
    .addr_d,
    .addr_s  (2'd0),
    .a_byte  (~rf_word_op),
    .b_byte  (~rf_word_op),
    .c_byte  (1'b0),
    .iflags,
    .a       (rf_a),
    .b       (rf_b),
    .c       (rd_data),
    .s       (),
    .cs, .ip, .flags, .cx_zero
  );

  alu i_alu (
    .op (alu_op), .word_op (rf_word_op), .x (rf_a), .y (y_op),
    .flags_in (flags), .result (alu_result), .flags_out (alu_flags)
  );

  shift_mul_unit i_shift_mul (
    .clk, .rst, .load (sm_load), .step (sm_step), .mode (alu_op),
    .word_op (rf_word_op), .x (rf_a), .y (y_op), .flags_in (flags),
    .result (sm_result), .flags_out (sm_flags)
  );

  step_counter i_counter (
    .clk, .rst, .load (cnt_load), .count_in (cnt_init), .dec (cnt_dec), .zero (cnt_zero)
  );

  exec_fsm i_fsm (
    .clk, .rst, .start, .op, .word_op_in (word_op), .dst, .src, .use_imm, .imm,
    .cl_count, .cnt_zero, .alu_result, .alu_flags, .sm_result, .sm_flags,
    .addr_a, .addr_b, .addr_d, .word_op (rf_word_op), .y_sel_imm,
    .wr, .wrhi, .wrfl, .cnt_load, .cnt_dec, .cnt_init, .sm_load, .sm_step,
    .busy, .done, .alu_op, .imm_q, .d, .iflags
  );

endmodule

// File: verilog/exec_fsm.sv
module exec_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                start,
  input  alu_pkg::op_e                        op,
  input  logic                                word_op_in,
  input  logic [cpu_pkg::reg_addr_w-1:0]      dst,
  input  logic [cpu_pkg::reg_addr_w-1:0]      src,
  input  logic                                use_imm,
  input  logic [cpu_pkg::word_w-1:0]          imm,
  input  logic [cpu_pkg::shift_cnt_mask-1:0]  cl_count,
  input  logic                                cnt_zero,
  input  logic [cpu_pkg::word_w-1:0]          alu_result,
  input  logic [cpu_pkg::flag_w-1:0]          alu_flags,
  input  logic [2*cpu_pkg::word_w-1:0]        sm_result,
  input  logic [cpu_pkg::flag_w-1:0]          sm_flags,
  output logic [cpu_pkg::reg_addr_w-1:0]      addr_a,
  output logic [cpu_pkg::reg_addr_w-1:0]      addr_b,
  output logic [cpu_pkg::reg_addr_w-1:0]      addr_d,
  output logic                                word_op,
  output logic                                y_sel_imm,
  output logic                                wr,
  output logic                                wrhi,
  output logic                                wrfl,
  output logic                                cnt_load,
  output logic                                cnt_dec,
  output logic [cpu_pkg::shift_cnt_mask-1:0]  cnt_init,
  output logic                                sm_load,
  output logic                                sm_step,
  output logic                                busy,
  output logic                                done,
  output alu_pkg::op_e                        alu_op,
  output logic [cpu_pkg::word_w-1:0]          imm_q,
  output logic [2*cpu_pkg::word_w-1:0]        d,
  output logic [cpu_pkg::flag_w-1:0]          iflags
);

  typedef enum logic [2:0] {st_idle, st_exec, st_load, st_run, st_write} state_e;

  state_e                          state, state_next;
  alu_pkg::op_e                    op_q;
  logic                            word_op_q, use_imm_q;
  logic [cpu_pkg::reg_addr_w-1:0]  dst_q, src_q;
  logic                            is_mul, is_shift, start_multi;

  always_ff @(posedge clk) begin
    if (rst) state <= st_idle;
    else     state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (start && state == st_idle) begin
      op_q      <= op;
      word_op_q <= word_op_in;
      dst_q     <= dst;
      src_q     <= src;
      use_imm_q <= use_imm;
      imm_q     <= imm;
    end
  end

  assign is_mul      = (op_q == alu_pkg::op_mul);
  assign is_shift    = (op_q == alu_pkg::op_shl) || (op_q == alu_pkg::op_shr);
  assign start_multi = (op == alu_pkg::op_shl) || (op == alu_pkg::op_shr) ||
                       (op == alu_pkg::op_mul);

  // The counter holds the steps still to go after the current one.
  always_comb begin
    state_next = state;
    case (state)
      st_idle:  if (start) state_next = start_multi ? st_load : st_exec;
      st_exec:  state_next = st_idle;
      st_load:  state_next = (!is_mul && cl_count == '0) ? st_write : st_run;
      st_run:   if (cnt_zero) state_next = st_write;
      st_write: state_next = st_idle;
      default:  state_next = st_idle;
    endcase
  end

  assign addr_a    = is_mul ? cpu_pkg::reg_ax : dst_q;
  assign addr_b    = is_shift ? cpu_pkg::reg_cx : src_q; // Shifts read CL here.
  assign addr_d    = is_mul ? cpu_pkg::reg_ax : dst_q;
  assign word_op   = word_op_q | is_mul;
  assign y_sel_imm = use_imm_q & ~is_shift;
  assign alu_op    = op_q;
  assign cnt_init  = is_mul ? 5'(alu_pkg::mul_steps - 1) : cl_count - 1'b1;

  assign busy     = (state != st_idle);
  assign done     = (state == st_exec) || (state == st_write);
  assign wr       = done;
  assign wrfl     = done;
  assign wrhi     = (state == st_write) && is_mul;
  assign cnt_load = (state == st_load);
  assign sm_load  = (state == st_load);
  assign cnt_dec  = (state == st_run);
  assign sm_step  = (state == st_run);

  assign d      = (state == st_write) ? sm_result : {16'h0000, alu_result};
  assign iflags = (state == st_write) ? sm_flags : alu_flags;

endmodule

// File: verilog/shift_mul_unit.sv
module shift_mul_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  logic                          step,
  input  alu_pkg::op_e                  mode,
  input  logic                          word_op,
  input  logic [cpu_pkg::word_w-1:0]    x,
  input  logic [cpu_pkg::word_w-1:0]    y,
  input  logic [cpu_pkg::flag_w-1:0]    flags_in,
  output logic [2*cpu_pkg::word_w-1:0]  result,
  output logic [cpu_pkg::flag_w-1:0]    flags_out
);

  logic [31:0] prod;  // Shift value in the low word, or the running product.
  logic [15:0] mcand;
  logic        cf_q;
  logic [16:0] partial;

  // Add the multiplicand into the upper half when the current multiplier bit is set.
  assign partial = prod[0] ? {1'b0, prod[31:16]} + {1'b0, mcand} : {1'b0, prod[31:16]};

  always_ff @(posedge clk) begin
    if (rst) begin
      prod  <= '0;
      mcand <= '0;
      cf_q  <= 1'b0;
    end else if (load) begin
      mcand <= x;
      cf_q  <= flags_in[alu_pkg::fl_cf];
      prod  <= (mode == alu_pkg::op_mul) ? {16'h0000, y} : {16'h0000, x};
    end else if (step) begin
      case (mode)
        alu_pkg::op_mul: prod <= {partial, prod[15:1]};
        alu_pkg::op_shl: begin
          cf_q       <= word_op ? prod[15] : prod[7];
          prod[15:0] <= {prod[14:0], 1'b0};
        end
        alu_pkg::op_shr: begin
          cf_q       <= prod[0];
          prod[15:0] <= word_op ? {1'b0, prod[15:1]} : {prod[15:8], 1'b0, prod[7:1]};
        end
        default: ;
      endcase
    end
  end

  assign result = prod;

  always_comb begin
    flags_out = flags_in;
    if (mode == alu_pkg::op_mul) begin
      flags_out[alu_pkg::fl_cf] = |prod[31:16];
      flags_out[alu_pkg::fl_of] = |prod[31:16];
    end else begin
      flags_out[alu_pkg::fl_cf] = cf_q;
      flags_out[alu_pkg::fl_of] = 1'b0;
      flags_out[alu_pkg::fl_zf] = word_op ? (prod[15:0] == '0) : (prod[7:0] == '0);
      flags_out[alu_pkg::fl_sf] = word_op ? prod[15] : prod[7];
      flags_out[alu_pkg::fl_pf] = ~^prod[7:0];
    end
  end

endmodule

// File: verilog/step_counter.sv
module step_counter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 load,
  input  logic [cpu_pkg::shift_cnt_mask-1:0]   count_in,
  input  logic                                 dec,
  output logic                                 zero
);

  logic [cpu_pkg::shift_cnt_mask-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= count_in;
    end else if (dec && !zero) begin
      count <= count - 1'b1; // Holds once it has run out.
    end
  end

  assign zero = (count == '0);

endmodule

// File: vlog.f
common/cpu_pkg.sv
common/alu_pkg.sv
regfile/regfile.sv
verilog/alu.sv
verilog/shift_mul_unit.sv
verilog/step_counter.sv
verilog/exec_fsm.sv
verilog/exec_core.sv
test/exec_checker.sv
test/tb_exec_core.sv
